/* Makefile */
# Verilator build and run of the scratch memory testbench.
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= scratch_mem_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := *** TEST FAILED ***
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "result: FAIL"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "result: FAIL, no pass line"; exit 1; fi
	@echo "result: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
source/mem_geom_pkg.sv
source/mem_bus_pkg.sv
source/byte_lane_ram.sv
source/busy_timer.sv
source/access_ctrl.sv
source/scratch_mem.sv
testbench/scratch_mem_props.sv
testbench/scratch_mem_tb.sv

/* source/access_ctrl.sv */
// access FSM: accepts requests while idle, runs one RAM cycle, waits for
// the busy timer and formats the response.
`timescale 1ns/1ps
`default_nettype none

module access_ctrl #(
    // length of the busy window, checked by the bound properties.
    parameter int BUSY_CYCLES = 3
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            req_valid,
    input  mem_bus_pkg::mem_req_t           req,
    output logic                            busy,
    output logic                            rsp_valid,
    output mem_bus_pkg::mem_rsp_t           rsp,
    output logic                            timer_start,
    input  logic                            timer_last,
    output logic                            ram_cs,
    output logic                            ram_we,
    output logic [mem_geom_pkg::ADDR_W-1:0] ram_addr,
    output mem_geom_pkg::word_t             ram_wdata,
    output mem_geom_pkg::lane_en_t          ram_byte_en,
    input  mem_geom_pkg::word_t             ram_rdata
);

    import mem_bus_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        HOLD
    } state_t;

    state_t   state;
    mem_req_t req_q;
    logic     accept;
    logic     done;

    // the response cycle is idle too, so back-to-back requests are taken.
    assign accept = req_valid && (state == IDLE);

    // last busy cycle, the timer only runs out while in HOLD.
    assign done = (state == HOLD) && timer_last;

    assign timer_start = accept;
    assign busy        = (state != IDLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= ACCESS;
                    end
                end
                ACCESS: begin
                    state <= HOLD;
                end
                HOLD: begin
                    if (timer_last) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // request payload, held for the whole access.
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // one RAM cycle right after the accept edge.
    assign ram_cs      = (state == ACCESS);
    assign ram_we      = (state == ACCESS) && (req_q.cmd == CMD_WRITE);
    assign ram_addr    = req_q.addr;
    assign ram_wdata   = req_q.wdata;
    assign ram_byte_en = req_q.byte_en;

    // response is offered once; rdata is still held by the RAM here.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
            rsp       <= '0;
        end else begin
            rsp_valid <= done;
            if (done) begin
                rsp.cmd   <= req_q.cmd;
                rsp.rdata <= (req_q.cmd == CMD_READ) ? ram_rdata : '0;
            end
        end
    end

endmodule : access_ctrl

`default_nettype wire

/* source/busy_timer.sv */
// down-counter that measures the busy window and flags its final cycle.
`timescale 1ns/1ps
`default_nettype none

module busy_timer #(
    parameter int BUSY_CYCLES = 3
) (
    input  logic clk,
    input  logic arst_n,
    input  logic start,
    output logic last
);

    localparam int CNT_W = $clog2(BUSY_CYCLES);

    logic [CNT_W-1:0] count;
    logic             running;

    // loaded at the accept edge, so the count reaches zero in the
    // last of the BUSY_CYCLES busy cycles.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count   <= '0;
            running <= 1'b0;
        end else if (start) begin
            count   <= CNT_W'(BUSY_CYCLES - 1);
            running <= 1'b1;
        end else if (running) begin
            if (count == '0) begin
                running <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign last = running && (count == '0);

endmodule : busy_timer

`default_nettype wire

/* source/byte_lane_ram.sv */
// byte array with per-lane offset addressing, masked synchronous write
// and a registered word read.
`timescale 1ns/1ps
`default_nettype none

module byte_lane_ram #(
    parameter int DEPTH_LOG2 = 6
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            cs,
    input  logic                            we,
    input  logic [mem_geom_pkg::ADDR_W-1:0] addr,
    input  mem_geom_pkg::word_t             wdata,
    input  mem_geom_pkg::lane_en_t          byte_en,
    output mem_geom_pkg::word_t             rdata
);

    import mem_geom_pkg::*;

    localparam int DEPTH = 2 ** DEPTH_LOG2;

    typedef logic [DEPTH_LOG2-1:0] ram_addr_t;

    lane_t     mem [DEPTH];
    ram_addr_t lane_addr [LANES];

    // lane i lives at addr+i, the truncation gives the wrap at the top
    // and drops address bits above DEPTH_LOG2.
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            lane_addr[i] = ram_addr_t'(addr + ADDR_W'(i));
        end
    end

    // masked write, one byte per enabled lane.
    always_ff @(posedge clk) begin
        if (cs && we) begin
            for (int i = 0; i < LANES; i++) begin
                if (byte_en[i]) begin
                    mem[lane_addr[i]] <= wdata[i];
                end
            end
        end
    end

    // read word is captured once and held until the next read.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else if (cs && !we) begin
            for (int i = 0; i < LANES; i++) begin
                rdata[i] <= mem[lane_addr[i]];
            end
        end
    end

endmodule : byte_lane_ram

`default_nettype wire

/* source/mem_bus_pkg.sv */
// bus side of the scratch memory: the command encoding and the request
// and response structs.
`default_nettype none

package mem_bus_pkg;

    import mem_geom_pkg::*;

    // access kind carried with each request.
    typedef enum logic {
        CMD_READ  = 1'b0,
        CMD_WRITE = 1'b1
    } mem_cmd_e;

    // request as sampled on the strobe, 53 bits.
    typedef struct packed {
        mem_cmd_e          cmd;
        logic [ADDR_W-1:0] addr;
        word_t             wdata;
        lane_en_t          byte_en;
    } mem_req_t;

    // response offered for one cycle, 33 bits.
    // rdata reads as zero for writes.
    typedef struct packed {
        mem_cmd_e cmd;
        word_t    rdata;
    } mem_rsp_t;

endpackage : mem_bus_pkg

`default_nettype wire

/* source/mem_geom_pkg.sv */
// geometry of the scratch memory: lane width, lanes per word, address field width
// and the storage types built from them.
`default_nettype none

package mem_geom_pkg;

    // bits in one byte lane.
    localparam int LANE_W = 8;

    // lanes in one bus word.
    localparam int LANES = 4;

    // width of the request address field.
    // the RAM uses only the low DEPTH_LOG2 bits of it.
    localparam int ADDR_W = 16;

    // one byte of storage.
    typedef logic [LANE_W-1:0] lane_t;

    // a bus word as packed lanes, lane 0 in the low byte.
    typedef lane_t [LANES-1:0] word_t;

    // one write enable per lane.
    typedef logic [LANES-1:0] lane_en_t;

endpackage : mem_geom_pkg

`default_nettype wire

/* source/scratch_mem.sv */
// scratch memory top level: access FSM, busy timer and byte-lane RAM.
`timescale 1ns/1ps
`default_nettype none

module scratch_mem #(
    parameter int DEPTH_LOG2  = 6,
    parameter int BUSY_CYCLES = 3
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  req_valid,
    input  mem_bus_pkg::mem_req_t req,
    output logic                  busy,
    output logic                  rsp_valid,
    output mem_bus_pkg::mem_rsp_t rsp
);

    import mem_geom_pkg::*;

    logic              timer_start;
    logic              timer_last;
    logic              ram_cs;
    logic              ram_we;
    logic [ADDR_W-1:0] ram_addr;
    word_t             ram_wdata;
    lane_en_t          ram_byte_en;
    word_t             ram_rdata;

    access_ctrl #(
        .BUSY_CYCLES (BUSY_CYCLES)
    ) u_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req         (req),
        .busy        (busy),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .timer_start (timer_start),
        .timer_last  (timer_last),
        .ram_cs      (ram_cs),
        .ram_we      (ram_we),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_byte_en (ram_byte_en),
        .ram_rdata   (ram_rdata)
    );

    busy_timer #(
        .BUSY_CYCLES (BUSY_CYCLES)
    ) u_timer (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (timer_start),
        .last   (timer_last)
    );

    byte_lane_ram #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) u_ram (
        .clk     (clk),
        .arst_n  (arst_n),
        .cs      (ram_cs),
        .we      (ram_we),
        .addr    (ram_addr),
        .wdata   (ram_wdata),
        .byte_en (ram_byte_en),
        .rdata   (ram_rdata)
    );

endmodule : scratch_mem

`default_nettype wire

/* testbench/scratch_mem_props.sv */
// concurrent checks on the access FSM: busy length, response and RAM strobes,
// and requests that arrive while busy.
`timescale 1ns/1ps
`default_nettype none

module scratch_mem_props #(
    parameter int BUSY_CYCLES = 3
) (
    input logic clk,
    input logic arst_n,
    input logic req_valid,
    input logic busy,
    input logic rsp_valid,
    input logic timer_start,
    input logic ram_cs
);

    int busy_len;

    // busy cycles seen before the current one.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_len <= 0;
        end else if (busy) begin
            busy_len <= busy_len + 1;
        end else begin
            busy_len <= 0;
        end
    end

    busy_not_long: assert property (@(posedge clk) disable iff (!arst_n)
        busy |-> busy_len < BUSY_CYCLES)
        else $error("busy longer than %0d cycles", BUSY_CYCLES);

    busy_not_short: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> busy_len == BUSY_CYCLES)
        else $error("busy shorter than %0d cycles", BUSY_CYCLES);

    rsp_apart: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> !busy)
        else $error("rsp_valid while busy");

    rsp_single: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |=> !rsp_valid)
        else $error("rsp_valid longer than one cycle");

    cs_after_accept: assert property (@(posedge clk) disable iff (!arst_n)
        timer_start |=> ram_cs)
        else $error("no RAM cycle after accept");

    cs_single: assert property (@(posedge clk) disable iff (!arst_n)
        ram_cs |=> !ram_cs)
        else $error("ram_cs longer than one cycle");

    // a dropped request must not start a new RAM cycle.
    drop_when_busy: assert property (@(posedge clk) disable iff (!arst_n)
        (req_valid && busy) |=> !ram_cs)
        else $error("request accepted while busy");

endmodule : scratch_mem_props

bind access_ctrl scratch_mem_props #(
    .BUSY_CYCLES (BUSY_CYCLES)
) u_props (
    .clk         (clk),
    .arst_n      (arst_n),
    .req_valid   (req_valid),
    .busy        (busy),
    .rsp_valid   (rsp_valid),
    .timer_start (timer_start),
    .ram_cs      (ram_cs)
);

`default_nettype wire

/* testbench/scratch_mem_tb.sv */
// testbench for the scratch memory: clock, reset, stimulus, byte-array reference
// model with response checking, and a cycle timeout.
`timescale 1ns/1ps
`default_nettype none

module scratch_mem_tb;

    import mem_geom_pkg::*;
    import mem_bus_pkg::*;

    localparam int DEPTH_LOG2  = 6;
    localparam int BUSY_CYCLES = 3;
    localparam int DEPTH       = 2 ** DEPTH_LOG2;
    localparam int WORDS       = DEPTH / LANES;
    localparam int N_MERGE     = 40;
    localparam int N_UNALIGNED = 20;
    // accepted accesses over all phases, dropped requests excluded.
    localparam int N_OPS = 2 * WORDS + N_MERGE + WORDS + 6 + 2 * N_UNALIGNED + 2 * BUSY_CYCLES;
    localparam int TIMEOUT_CYCLES = N_OPS * (BUSY_CYCLES + 2) + 100;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DEPTH_LOG2-1:0] ram_idx_t;

    logic     clk = 1'b0;
    logic     arst_n;
    logic     req_valid;
    mem_req_t req;
    logic     busy;
    logic     rsp_valid;
    mem_rsp_t rsp;

    lane_t    model_mem [DEPTH];
    bit       written [DEPTH];
    mem_rsp_t exp_q [$];
    mem_rsp_t rsp_exp;
    int       accept_count = 0;
    int       rsp_count = 0;
    int       cycle_count = 0;
    int       seed = 32'h566f;

    scratch_mem #(
        .DEPTH_LOG2  (DEPTH_LOG2),
        .BUSY_CYCLES (BUSY_CYCLES)
    ) u_scratch_mem (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    always #10 clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic fail_value(input string msg);
        stop_run($sformatf("Fail at %0t: %s", $time, msg));
    endtask

    task automatic check_rsp(input mem_rsp_t expected, input mem_rsp_t act);
        if (act !== expected) begin
            fail_value($sformatf("rsp cmd=%s rdata=%h, expected cmd=%s rdata=%h",
                                 act.cmd.name(), act.rdata,
                                 expected.cmd.name(), expected.rdata));
        end
    endtask

    task automatic check_busy(input logic expected, input logic act);
        if (act !== expected) begin
            fail_value($sformatf("busy is %b, expected %b", act, expected));
        end
    endtask

    // byte address of lane i, wrapped to the memory size.
    function automatic ram_idx_t lane_index(input addr_t addr, input int lane);
        return ram_idx_t'((int'(addr) + lane) % DEPTH);
    endfunction

    // expected response from the model; writes answer with zero data.
    function automatic mem_rsp_t expected_rsp(input mem_req_t r);
        mem_rsp_t e;
        e.cmd   = r.cmd;
        e.rdata = '0;
        if (r.cmd == CMD_READ) begin
            for (int i = 0; i < LANES; i++) begin
                e.rdata[i] = model_mem[lane_index(r.addr, i)];
            end
        end
        return e;
    endfunction

    function automatic void model_write(input mem_req_t r);
        for (int i = 0; i < LANES; i++) begin
            if (r.byte_en[i]) begin
                model_mem[lane_index(r.addr, i)] = r.wdata[i];
                written[lane_index(r.addr, i)]   = 1'b1;
            end
        end
    endfunction

    function automatic mem_req_t make_req(input mem_cmd_e cmd, input addr_t addr,
                                          input word_t wdata, input lane_en_t byte_en);
        mem_req_t r;
        r.cmd     = cmd;
        r.addr    = addr;
        r.wdata   = wdata;
        r.byte_en = byte_en;
        return r;
    endfunction

    // low bits as given, random bits above the memory size.
    function automatic addr_t with_random_upper(input int low);
        return addr_t'(low) | (addr_t'($random(seed)) & ~addr_t'(DEPTH - 1));
    endfunction

    // counts busy cycles until the response, optionally strobing a second
    // request in busy cycle intrude_at.
    task automatic wait_response(input mem_req_t intruder, input int intrude_at);
        int n;
        n = 0;
        while (rsp_valid !== 1'b1) begin
            n++;
            check_busy(n <= BUSY_CYCLES, busy);
            if (n == intrude_at) begin
                req_valid = 1'b1;
                req       = intruder;
            end else begin
                req_valid = 1'b0;
            end
            @(negedge clk);
        end
        req_valid = 1'b0;
        if (n != BUSY_CYCLES) begin
            fail_value($sformatf("response after %0d busy cycles, expected %0d",
                                 n, BUSY_CYCLES));
        end
        check_busy(1'b0, busy);
    endtask

    // called at a falling edge of an idle cycle.
    task automatic do_access(input mem_req_t r, input int intrude_at);
        mem_req_t intruder;
        if (r.cmd == CMD_READ) begin
            for (int i = 0; i < LANES; i++) begin
                if (!written[lane_index(r.addr, i)]) begin
                    stop_run("test sequence reads a byte that was never written");
                end
            end
        end
        exp_q.push_back(expected_rsp(r));
        if (r.cmd == CMD_WRITE) begin
            model_write(r);
        end
        accept_count++;
        req_valid = 1'b1;
        req       = r;
        // a full write of inverted data would show up on the next read.
        intruder         = r;
        intruder.cmd     = CMD_WRITE;
        intruder.wdata   = ~r.wdata;
        intruder.byte_en = '1;
        @(negedge clk);
        wait_response(intruder, intrude_at);
    endtask

    always @(negedge clk) begin
        if (rsp_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                stop_run("a response arrived with no request outstanding");
            end else begin
                rsp_exp = exp_q.pop_front();
                check_rsp(rsp_exp, rsp);
                rsp_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_run($sformatf("timeout, run still going after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        mem_req_t r;
        addr_t    a;
        word_t    d;
        lane_en_t e;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        check_busy(1'b0, busy);
        if (rsp_valid !== 1'b0) begin
            fail_value("rsp_valid high after reset");
        end
        check_rsp(mem_rsp_t'('0), rsp);

        // fill the whole memory with aligned full words.
        for (int w = 0; w < WORDS; w++) begin
            d = word_t'($random(seed));
            do_access(make_req(CMD_WRITE, with_random_upper(w * LANES), d, '1), 0);
        end
        for (int w = 0; w < WORDS; w++) begin
            do_access(make_req(CMD_READ, with_random_upper(w * LANES), '0, '0), 0);
        end

        // byte merge with random enables.
        for (int k = 0; k < N_MERGE; k++) begin
            a = addr_t'($random(seed)) & ~addr_t'(LANES - 1);
            d = word_t'($random(seed));
            e = lane_en_t'($random(seed));
            do_access(make_req(CMD_WRITE, a, d, e), 0);
        end
        for (int w = 0; w < WORDS; w++) begin
            do_access(make_req(CMD_READ, addr_t'(w * LANES), '0, '0), 0);
        end

        // accesses that run over the top of the memory.
        for (int k = 3; k >= 1; k--) begin
            d = word_t'($random(seed));
            e = lane_en_t'($random(seed));
            do_access(make_req(CMD_WRITE, with_random_upper(DEPTH - k), d, e), 0);
        end
        for (int k = 3; k >= 1; k--) begin
            do_access(make_req(CMD_READ, with_random_upper(DEPTH - k), '0, '0), 0);
        end
        for (int k = 0; k < N_UNALIGNED; k++) begin
            a = addr_t'($random(seed));
            if (a[1:0] == 2'b00) begin
                a[0] = 1'b1;
            end
            d = word_t'($random(seed));
            e = lane_en_t'($random(seed));
            r = make_req(CMD_WRITE, a, d, e);
            do_access(r, 0);
            do_access(make_req(CMD_READ, a, '0, '0), 0);
        end

        // a second strobe in each busy cycle must be dropped.
        for (int k = 1; k <= BUSY_CYCLES; k++) begin
            a = addr_t'($random(seed));
            d = word_t'($random(seed));
            do_access(make_req(CMD_WRITE, a, d, '1), k);
            do_access(make_req(CMD_READ, a, '0, '0), 0);
        end

        @(negedge clk);
        if (rsp_count == accept_count && exp_q.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            stop_run($sformatf("%0d responses for %0d accepted requests",
                               rsp_count, accept_count));
        end
    end

endmodule : scratch_mem_tb

`default_nettype wire
